/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tbSynth -o tbSynth

run: compile
	@out=$$(./obj_dir/tbSynth); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+source
source/synthRegPkg.sv
source/synthVoicePkg.sv
source/spiSlave.sv
source/synthControl.sv
source/phaseAccumulator.sv
source/waveformGenerator.sv
source/sampleMixer.sv
source/synth.sv
tb/tbSynth.sv

/* source/phaseAccumulator.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module phaseAccumulator (
    input  logic                   i_Clock,
    input  logic                   i_rst,
    input  synthVoicePkg::slot_t   i_Slot,
    input  synthVoicePkg::slot_t   i_WriteSlot,
    input  logic [15:0]            i_WriteData,
    input  logic                   i_PhaseStepWrite,
    input  logic                   i_NoteOnWrite,
    output synthVoicePkg::slot_t   o_Slot,
    output synthVoicePkg::phase_t  o_Phase,
    output logic                   o_NoteOn
);

    synthVoicePkg::phase_t r_PhaseStep [`NUM_SLOTS];
    synthVoicePkg::phase_t r_Phase [`NUM_SLOTS];
    logic                  r_NoteOn [`NUM_SLOTS];

    synthVoicePkg::phase_t w_NextPhase;

    // Silent slots restart from phase 0
    assign w_NextPhase = r_NoteOn[i_Slot] ? r_Phase[i_Slot] + r_PhaseStep[i_Slot] : '0;

    always_ff @(posedge i_Clock) begin
        if (i_PhaseStepWrite) begin
            r_PhaseStep[i_WriteSlot] <= i_WriteData;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                r_Phase[i]  <= '0;
                r_NoteOn[i] <= 1'b0;
            end
            o_Slot   <= '0;
            o_Phase  <= '0;
            o_NoteOn <= 1'b0;
        end else begin
            r_Phase[i_Slot] <= w_NextPhase;
            // Note-on is value bit 0
            if (i_NoteOnWrite) begin
                r_NoteOn[i_WriteSlot] <= i_WriteData[0];
            end
            o_Slot   <= i_Slot;
            o_Phase  <= w_NextPhase;
            o_NoteOn <= r_NoteOn[i_Slot];
        end
    end

endmodule

/* source/sampleMixer.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module sampleMixer (
    input  logic                     i_Clock,
    input  logic                     i_rst,
    input  synthVoicePkg::slot_t     i_Slot,
    input  synthVoicePkg::sample_t   i_Waveform,
    input  synthVoicePkg::slot_t     i_WriteSlot,
    input  logic [15:0]              i_WriteData,
    input  logic                     i_LevelWrite,
    input  logic                     i_CarrierWrite,
    output logic                     o_SampleReady,
    output synthVoicePkg::sample_t   o_Sample
);

    // Scaled term is 17 bits, headroom for every slot
    localparam int ACC_BITS = 17 + `SLOT_BITS;
    localparam logic signed [ACC_BITS-1:0] SAT_MAX = 32767;
    localparam logic signed [ACC_BITS-1:0] SAT_MIN = -32768;

    logic [7:0] r_Level [`NUM_SLOTS];
    logic       r_Carrier [`NUM_SLOTS];

    logic signed [ACC_BITS-1:0] r_Acc;

    logic signed [24:0]         w_Product;
    logic signed [16:0]         w_Scaled;
    logic signed [ACC_BITS-1:0] w_Term;
    logic signed [ACC_BITS-1:0] w_Sum;
    logic                       w_LastSlot;

    // Level is unsigned, zero-extend before the signed multiply
    assign w_Product  = i_Waveform * $signed({1'b0, r_Level[i_Slot]});
    // Arithmetic shift right by 8
    assign w_Scaled   = w_Product[24:8];
    assign w_Term     = r_Carrier[i_Slot] ? ACC_BITS'(w_Scaled) : '0;
    assign w_Sum      = r_Acc + w_Term;
    assign w_LastSlot = i_Slot == synthVoicePkg::slot_t'(`NUM_SLOTS - 1);

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                r_Level[i]   <= '0;
                r_Carrier[i] <= 1'b0;
            end
            r_Acc         <= '0;
            o_SampleReady <= 1'b0;
            o_Sample      <= '0;
        end else begin
            if (i_LevelWrite) begin
                r_Level[i_WriteSlot] <= i_WriteData[7:0];
            end
            if (i_CarrierWrite) begin
                r_Carrier[i_WriteSlot] <= i_WriteData[0];
            end
            o_SampleReady <= w_LastSlot;
            if (w_LastSlot) begin
                // Frame done, clamp to 16 bits and restart
                r_Acc <= '0;
                if (w_Sum > SAT_MAX) begin
                    o_Sample <= 16'sh7FFF;
                end else if (w_Sum < SAT_MIN) begin
                    o_Sample <= 16'sh8000;
                end else begin
                    o_Sample <= w_Sum[15:0];
                end
            end else begin
                r_Acc <= w_Sum;
            end
        end
    end

endmodule

/* source/spiSlave.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module spiSlave (
    input  logic                       i_Clock,
    input  logic                       i_rst,
    input  logic                       i_SpiNss,
    input  logic                       i_SpiSck,
    input  logic                       i_SpiMosi,
    input  logic                       i_SampleReady,
    input  synthVoicePkg::sample_t     i_Sample,
    output logic                       o_SpiMiso,
    output logic                       o_WriteValid,
    output synthRegPkg::regNumber_u    o_RegNumber,
    output logic [15:0]                o_RegValue
);

    // One spare bit so a too-long frame never matches
    localparam int COUNT_BITS = $clog2(`SPI_FRAME_BITS) + 1;

    // [1] is the synchronized level, [2] the previous one
    logic [2:0] r_NssSync;
    logic [2:0] r_SckSync;
    logic [1:0] r_MosiSync;

    logic [`SPI_FRAME_BITS-1:0] r_RxShift;
    logic [COUNT_BITS-1:0]      r_BitCount;
    logic [15:0]                r_TxShift;
    synthVoicePkg::sample_t     r_LatestSample;

    logic w_NssFall;
    logic w_NssRise;
    logic w_SckRise;
    logic w_SckFall;
    logic w_Active;

    assign w_NssFall = r_NssSync[2] & ~r_NssSync[1];
    assign w_NssRise = ~r_NssSync[2] & r_NssSync[1];
    assign w_SckRise = ~r_SckSync[2] & r_SckSync[1];
    assign w_SckFall = r_SckSync[2] & ~r_SckSync[1];
    assign w_Active  = ~r_NssSync[1];

    // MSB of the outgoing sample
    assign o_SpiMiso = r_TxShift[15];

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            // NSS idles high
            r_NssSync      <= '1;
            r_SckSync      <= '0;
            r_BitCount     <= '0;
            r_TxShift      <= '0;
            r_LatestSample <= '0;
            o_WriteValid   <= 1'b0;
        end else begin
            r_NssSync <= {r_NssSync[1:0], i_SpiNss};
            r_SckSync <= {r_SckSync[1:0], i_SpiSck};

            // Keep newest mixer output for the next frame
            if (i_SampleReady) begin
                r_LatestSample <= i_Sample;
            end

            if (w_NssFall) begin
                // Frame start
                r_BitCount   <= '0;
                r_TxShift    <= r_LatestSample;
                o_WriteValid <= 1'b0;
            end else if (w_NssRise) begin
                // Accept only complete frames
                o_WriteValid <= (r_BitCount == COUNT_BITS'(`SPI_FRAME_BITS));
            end else if (w_Active) begin
                if (w_SckRise && r_BitCount != '1) begin
                    r_BitCount <= r_BitCount + 1'b1;
                end
                // Mode 0, next MISO bit on falling SCK
                if (w_SckFall) begin
                    r_TxShift <= {r_TxShift[14:0], 1'b0};
                end
            end
        end
    end

    // Data path, no reset
    always_ff @(posedge i_Clock) begin
        r_MosiSync <= {r_MosiSync[0], i_SpiMosi};
        if (w_Active && w_SckRise) begin
            r_RxShift <= {r_RxShift[`SPI_FRAME_BITS-2:0], r_MosiSync[1]};
        end
        if (w_NssRise) begin
            o_RegNumber <= r_RxShift[`SPI_FRAME_BITS-1 -: 16];
            o_RegValue  <= r_RxShift[15:0];
        end
    end

endmodule

/* source/synth.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module synth (
    input  logic i_Clock,
    input  logic i_rst,
    input  logic i_SpiNss,
    input  logic i_SpiSck,
    input  logic i_SpiMosi,
    output logic o_SpiMiso,
    output logic o_Led
);

    // SPI to control
    logic                    w_WriteValid;
    synthRegPkg::regNumber_u w_RegNumber;
    logic [15:0]             w_RegValue;

    // Control to the pipeline
    synthVoicePkg::slot_t    w_HeadSlot;
    synthVoicePkg::slot_t    w_WriteSlot;
    logic [15:0]             w_WriteData;
    logic [`TABLE_BITS-1:0]  w_TableAddr;
    logic                    w_PhaseStepWrite;
    logic                    w_NoteOnWrite;
    logic                    w_CarrierWrite;
    logic                    w_LevelWrite;
    logic                    w_TableWrite;

    // Between stages
    synthVoicePkg::slot_t    w_PhaseSlot;
    synthVoicePkg::phase_t   w_Phase;
    logic                    w_NoteOn;
    synthVoicePkg::slot_t    w_WaveSlot;
    synthVoicePkg::sample_t  w_Waveform;

    // Mixer back to SPI
    logic                    w_SampleReady;
    synthVoicePkg::sample_t  w_Sample;

    spiSlave spi0 (
        .i_Clock       (i_Clock),
        .i_rst         (i_rst),
        .i_SpiNss      (i_SpiNss),
        .i_SpiSck      (i_SpiSck),
        .i_SpiMosi     (i_SpiMosi),
        .i_SampleReady (w_SampleReady),
        .i_Sample      (w_Sample),
        .o_SpiMiso     (o_SpiMiso),
        .o_WriteValid  (w_WriteValid),
        .o_RegNumber   (w_RegNumber),
        .o_RegValue    (w_RegValue)
    );

    synthControl control0 (
        .i_Clock          (i_Clock),
        .i_rst            (i_rst),
        .i_WriteValid     (w_WriteValid),
        .i_RegNumber      (w_RegNumber),
        .i_RegValue       (w_RegValue),
        .o_Slot           (w_HeadSlot),
        .o_WriteSlot      (w_WriteSlot),
        .o_WriteData      (w_WriteData),
        .o_TableAddr      (w_TableAddr),
        .o_PhaseStepWrite (w_PhaseStepWrite),
        .o_NoteOnWrite    (w_NoteOnWrite),
        .o_CarrierWrite   (w_CarrierWrite),
        .o_LevelWrite     (w_LevelWrite),
        .o_TableWrite     (w_TableWrite),
        .o_Led            (o_Led)
    );

    phaseAccumulator phaseAcc0 (
        .i_Clock          (i_Clock),
        .i_rst            (i_rst),
        .i_Slot           (w_HeadSlot),
        .i_WriteSlot      (w_WriteSlot),
        .i_WriteData      (w_WriteData),
        .i_PhaseStepWrite (w_PhaseStepWrite),
        .i_NoteOnWrite    (w_NoteOnWrite),
        .o_Slot           (w_PhaseSlot),
        .o_Phase          (w_Phase),
        .o_NoteOn         (w_NoteOn)
    );

    waveformGenerator waveform0 (
        .i_Clock      (i_Clock),
        .i_rst        (i_rst),
        .i_Slot       (w_PhaseSlot),
        .i_Phase      (w_Phase),
        .i_NoteOn     (w_NoteOn),
        .i_TableWrite (w_TableWrite),
        .i_TableAddr  (w_TableAddr),
        .i_WriteData  (w_WriteData),
        .o_Slot       (w_WaveSlot),
        .o_Waveform   (w_Waveform)
    );

    sampleMixer mixer0 (
        .i_Clock        (i_Clock),
        .i_rst          (i_rst),
        .i_Slot         (w_WaveSlot),
        .i_Waveform     (w_Waveform),
        .i_WriteSlot    (w_WriteSlot),
        .i_WriteData    (w_WriteData),
        .i_LevelWrite   (w_LevelWrite),
        .i_CarrierWrite (w_CarrierWrite),
        .o_SampleReady  (w_SampleReady),
        .o_Sample       (w_Sample)
    );

endmodule

/* source/synthControl.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module synthControl (
    input  logic                       i_Clock,
    input  logic                       i_rst,
    input  logic                       i_WriteValid,
    input  synthRegPkg::regNumber_u    i_RegNumber,
    input  logic [15:0]                i_RegValue,
    output synthVoicePkg::slot_t       o_Slot,
    output synthVoicePkg::slot_t       o_WriteSlot,
    output logic [15:0]                o_WriteData,
    output logic [`TABLE_BITS-1:0]     o_TableAddr,
    output logic                       o_PhaseStepWrite,
    output logic                       o_NoteOnWrite,
    output logic                       o_CarrierWrite,
    output logic                       o_LevelWrite,
    output logic                       o_TableWrite,
    output logic                       o_Led
);

    logic       r_WriteValidLast;
    logic       w_WriteStrobe;
    logic       w_IsVoiceOp;
    logic       w_IsTable;
    logic [5:0] w_Param;

    // One strobe per accepted frame
    assign w_WriteStrobe = i_WriteValid & ~r_WriteValidLast;

    // Two readings of the same register number
    always_comb begin
        w_IsVoiceOp = i_RegNumber.voiceOp.prefix == synthRegPkg::PREFIX_VOICE_OP;
        w_IsTable   = i_RegNumber.tableEntry.prefix == synthRegPkg::PREFIX_TABLE;
        w_Param     = i_RegNumber.voiceOp.paramCode;
    end

    // Voice-operator write of the given parameter
    function automatic logic paramHit(input logic [5:0] code);
        return w_WriteStrobe && w_IsVoiceOp && w_Param == code;
    endfunction

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            r_WriteValidLast <= 1'b0;
            o_PhaseStepWrite <= 1'b0;
            o_NoteOnWrite    <= 1'b0;
            o_CarrierWrite   <= 1'b0;
            o_LevelWrite     <= 1'b0;
            o_TableWrite     <= 1'b0;
            o_Led            <= 1'b0;
        end else begin
            r_WriteValidLast <= i_WriteValid;
            o_PhaseStepWrite <= paramHit(synthRegPkg::PARAM_PHASE_STEP);
            o_NoteOnWrite    <= paramHit(synthRegPkg::PARAM_NOTE_ON);
            o_CarrierWrite   <= paramHit(synthRegPkg::PARAM_CARRIER);
            o_LevelWrite     <= paramHit(synthRegPkg::PARAM_LEVEL);
            o_TableWrite     <= w_WriteStrobe && w_IsTable;
            // LED is lit by any of value bits 7..4
            if (paramHit(synthRegPkg::PARAM_LED)) begin
                o_Led <= |i_RegValue[7:4];
            end
        end
    end

    // Write payload, valid alongside the strobes
    always_ff @(posedge i_Clock) begin
        if (w_WriteStrobe) begin
            o_WriteData <= i_RegValue;
            o_WriteSlot <= synthVoicePkg::slot_t'(
                i_RegNumber.voiceOp.opIndex * `NUM_VOICES + i_RegNumber.voiceOp.voice);
            o_TableAddr <= i_RegNumber.tableEntry.tableAddr[`TABLE_BITS-1:0];
        end
    end

    // Free-running slot counter, pipeline head
    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            o_Slot <= '0;
        end else if (o_Slot == synthVoicePkg::slot_t'(`NUM_SLOTS - 1)) begin
            o_Slot <= '0;
        end else begin
            o_Slot <= o_Slot + 1'b1;
        end
    end

endmodule

/* source/synthRegPkg.sv */
package synthRegPkg;

    // Register number 11 PPPPPP VVVVV OOO
    typedef struct packed {
        logic [1:0] prefix;
        logic [5:0] paramCode;
        logic [4:0] voice;
        logic [2:0] opIndex;
    } voiceOpReg_t;

    // Register number 10 AAAAAAAAAAAAAA
    typedef struct packed {
        logic [1:0]  prefix;
        logic [13:0] tableAddr;
    } tableReg_t;

    // Same 16 bits, read per prefix
    typedef union packed {
        voiceOpReg_t voiceOp;
        tableReg_t   tableEntry;
    } regNumber_u;

    localparam logic [1:0] PREFIX_VOICE_OP = 2'b11;
    localparam logic [1:0] PREFIX_TABLE    = 2'b10;

    // Voice-operator parameter codes
    localparam logic [5:0] PARAM_PHASE_STEP = 6'h00;
    localparam logic [5:0] PARAM_CARRIER    = 6'h01;
    localparam logic [5:0] PARAM_LEVEL      = 6'h02;
    localparam logic [5:0] PARAM_NOTE_ON    = 6'h10;
    localparam logic [5:0] PARAM_LED        = 6'h12;

endpackage

/* source/synthVoicePkg.sv */
`include "synth_config.svh"

package synthVoicePkg;

    // Slot index
    // Operator in the high bits, voice in the low bits
    typedef logic [`SLOT_BITS-1:0] slot_t;

    // Unsigned phase, top bits index the sine table
    typedef logic [15:0] phase_t;

    // Signed audio sample or table value
    typedef logic signed [15:0] sample_t;

endpackage

/* source/synth_config.svh */
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// Engine size
`define NUM_VOICES 4
`define NUM_OPERATORS 2

// Slots per sample frame, one per voice-operator pair
`define NUM_SLOTS (`NUM_VOICES * `NUM_OPERATORS)

// log2 of the slot count
`define SLOT_BITS 3

// Sine table has 2**TABLE_BITS entries
`define TABLE_BITS 8

// One SPI write frame: register number then value
`define SPI_FRAME_BITS 32

`endif

/* source/waveformGenerator.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module waveformGenerator (
    input  logic                     i_Clock,
    input  logic                     i_rst,
    input  synthVoicePkg::slot_t     i_Slot,
    input  synthVoicePkg::phase_t    i_Phase,
    input  logic                     i_NoteOn,
    input  logic                     i_TableWrite,
    input  logic [`TABLE_BITS-1:0]   i_TableAddr,
    input  logic [15:0]              i_WriteData,
    output synthVoicePkg::slot_t     o_Slot,
    output synthVoicePkg::sample_t   o_Waveform
);

    localparam int TABLE_SIZE = 2 ** `TABLE_BITS;

    // Sine table, loaded over SPI
    synthVoicePkg::sample_t r_Table [TABLE_SIZE];

    logic [`TABLE_BITS-1:0] w_Index;

    // Top phase bits pick the entry
    assign w_Index = i_Phase[15 -: `TABLE_BITS];

    always_ff @(posedge i_Clock) begin
        if (i_TableWrite) begin
            r_Table[i_TableAddr] <= synthVoicePkg::sample_t'(i_WriteData);
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            o_Slot     <= '0;
            o_Waveform <= '0;
        end else begin
            o_Slot <= i_Slot;
            // Silent slot contributes zero
            if (i_NoteOn) begin
                o_Waveform <= r_Table[w_Index];
            end else begin
                o_Waveform <= '0;
            end
        end
    end

endmodule

/* tb/tbSynth.sv */
`timescale 1ns/1ns
`include "synth_config.svh"

module tbSynth;

    // SPI clocks per bit split evenly between low and high
    localparam int BIT_CLOCKS = 8;
    localparam int SETTLE_TIMEOUT = 64;
    localparam int TABLE_SIZE = 2 ** `TABLE_BITS;
    localparam longint SAMPLE_MAX = 32767;
    localparam longint SAMPLE_MIN = -32768;

    logic clock;
    logic rst;
    logic spiNss;
    logic spiSck;
    logic spiMosi;
    logic spiMiso;
    logic led;

    // Expected contents of the per-slot stores
    logic [7:0]  modelLevel [`NUM_SLOTS];
    logic        modelCarrier [`NUM_SLOTS];
    logic        modelNoteOn [`NUM_SLOTS];

    logic [31:0] lcgState;
    int          errorCount;
    int          testCount;

    synth DUT (
        .i_Clock   (clock),
        .i_rst     (rst),
        .i_SpiNss  (spiNss),
        .i_SpiSck  (spiSck),
        .i_SpiMosi (spiMosi),
        .o_SpiMiso (spiMiso),
        .o_Led     (led)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Register number of a voice-operator parameter for one slot
    function automatic logic [15:0] voiceOpNumber(input logic [5:0] code, input int slot);
        synthRegPkg::regNumber_u number;
        number.voiceOp.prefix    = synthRegPkg::PREFIX_VOICE_OP;
        number.voiceOp.paramCode = code;
        number.voiceOp.voice     = 5'(slot % `NUM_VOICES);
        number.voiceOp.opIndex   = 3'(slot / `NUM_VOICES);
        return number;
    endfunction

    function automatic logic [15:0] tableNumber(input int addr);
        synthRegPkg::regNumber_u number;
        number.tableEntry.prefix    = synthRegPkg::PREFIX_TABLE;
        number.tableEntry.tableAddr = 14'(addr);
        return number;
    endfunction

    // Carriers with note-on add value * level >>> 8 before the clamp
    function automatic synthVoicePkg::sample_t expectedSample(
        input synthVoicePkg::sample_t tableValue);
        longint sum;
        longint term;
        sum = 0;
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            if (modelCarrier[s] && modelNoteOn[s]) begin
                term = longint'(tableValue) * longint'(modelLevel[s]);
                sum += term >>> 8;
            end
        end
        if (sum > SAMPLE_MAX) begin
            return 16'sh7FFF;
        end else if (sum < SAMPLE_MIN) begin
            return 16'sh8000;
        end
        return synthVoicePkg::sample_t'(sum);
    endfunction

    // One 32-bit mode-0 frame gathering the MISO word over the first 16 bits
    task automatic spiFrame(input logic [15:0] regNumber, input logic [15:0] regValue,
                            output synthVoicePkg::sample_t misoWord);
        logic [31:0] frame;
        frame = {regNumber, regValue};
        misoWord = '0;
        @(negedge clock);
        spiNss = 1'b0;
        // Room for the slave to load its sample
        repeat (BIT_CLOCKS) @(negedge clock);
        for (int b = 31; b >= 0; b--) begin
            spiMosi = frame[b];
            repeat (BIT_CLOCKS / 2) @(negedge clock);
            // MISO settled since last falling SCK
            if (b >= 16) begin
                misoWord = {misoWord[14:0], spiMiso};
            end
            spiSck = 1'b1;
            repeat (BIT_CLOCKS / 2) @(negedge clock);
            spiSck = 1'b0;
        end
        repeat (BIT_CLOCKS / 2) @(negedge clock);
        spiNss = 1'b1;
        // Write valid plus strobe land within a few clocks
        repeat (BIT_CLOCKS) @(negedge clock);
    endtask

    task automatic writeReg(input logic [15:0] regNumber, input logic [15:0] regValue);
        synthVoicePkg::sample_t unused;
        spiFrame(regNumber, regValue, unused);
    endtask

    task automatic readSample(output synthVoicePkg::sample_t value);
        spiFrame(16'h0000, 16'h0000, value);
    endtask

    // Let several mixer frames pass after a config change
    task automatic waitSamples(input int count);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < count && cycles <= SETTLE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
            if (DUT.w_SampleReady) begin
                seen++;
            end
        end
        if (seen < count) begin
            $display("ERROR: no sample ready pulse within %0d cycles", SETTLE_TIMEOUT);
            errorCount++;
        end
    endtask

    task automatic configureSlot(input int slot, input logic [7:0] level,
                                 input logic carrier, input logic noteOn);
        writeReg(voiceOpNumber(synthRegPkg::PARAM_LEVEL, slot), {8'h00, level});
        writeReg(voiceOpNumber(synthRegPkg::PARAM_CARRIER, slot), {15'h0, carrier});
        writeReg(voiceOpNumber(synthRegPkg::PARAM_NOTE_ON, slot), {15'h0, noteOn});
        modelLevel[slot]   = level;
        modelCarrier[slot] = carrier;
        modelNoteOn[slot]  = noteOn;
    endtask

    task automatic fillTable(input synthVoicePkg::sample_t value);
        for (int a = 0; a < TABLE_SIZE; a++) begin
            writeReg(tableNumber(a), value);
        end
    endtask

    // Step 0 everywhere keeps the phase at entry 0
    task automatic clearPhaseSteps();
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            writeReg(voiceOpNumber(synthRegPkg::PARAM_PHASE_STEP, s), 16'h0000);
        end
    endtask

    task automatic compareSample(input string testName, input synthVoicePkg::sample_t expected,
                                 input synthVoicePkg::sample_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0d, actual %0d", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareLed(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b, actual %b", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string testName, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("test %s: ok", testName);
        end else begin
            $display("test %s: failed with %0d errors", testName, errorCount - startErrors);
        end
    endtask

    task automatic resetDefaults();
        int startErrors;
        synthVoicePkg::sample_t value;
        startErrors = errorCount;
        compareLed("reset led", 1'b0, led);
        readSample(value);
        compareSample("reset sample", 16'sd0, value);
        finishTest("reset", startErrors);
    endtask

    task automatic ledWrites();
        int startErrors;
        logic [15:0] ignored;
        startErrors = errorCount;
        writeReg(voiceOpNumber(synthRegPkg::PARAM_LED, 0), 16'h00F0);
        compareLed("led high nibble", 1'b1, led);
        writeReg(voiceOpNumber(synthRegPkg::PARAM_LED, 0), 16'h000F);
        compareLed("led low nibble", 1'b0, led);
        writeReg(voiceOpNumber(synthRegPkg::PARAM_LED, 0), 16'h0040);
        compareLed("led bit 6", 1'b1, led);
        // Prefix 00 must be ignored
        ignored = voiceOpNumber(synthRegPkg::PARAM_LED, 0);
        ignored[15:14] = 2'b00;
        writeReg(ignored, 16'h0000);
        compareLed("led prefix 00", 1'b1, led);
        finishTest("led", startErrors);
    endtask

    task automatic singleCarrier();
        int startErrors;
        synthVoicePkg::sample_t value;
        startErrors = errorCount;
        fillTable(16'sd12000);
        configureSlot(5, 8'd200, 1'b1, 1'b1);
        waitSamples(4);
        readSample(value);
        compareSample("single carrier", expectedSample(16'sd12000), value);
        finishTest("single carrier", startErrors);
    endtask

    task automatic randomMix();
        int startErrors;
        logic [31:0] rnd;
        synthVoicePkg::sample_t tableValue;
        synthVoicePkg::sample_t value;
        startErrors = errorCount;
        for (int round = 0; round < 5; round++) begin
            rnd = lcgNext();
            tableValue = synthVoicePkg::sample_t'(rnd[15:0]);
            fillTable(tableValue);
            for (int s = 0; s < `NUM_SLOTS; s++) begin
                rnd = lcgNext();
                configureSlot(s, rnd[7:0], rnd[8], rnd[9]);
            end
            waitSamples(4);
            readSample(value);
            compareSample($sformatf("mixing round %0d", round), expectedSample(tableValue), value);
        end
        // Full scale on every slot pushes the sum past both limits
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            configureSlot(s, 8'hFF, 1'b1, 1'b1);
        end
        fillTable(16'sh7FFF);
        waitSamples(4);
        readSample(value);
        compareSample("mixing upper limit", 16'sh7FFF, value);
        fillTable(16'sh8000);
        waitSamples(4);
        readSample(value);
        compareSample("mixing lower limit", 16'sh8000, value);
        finishTest("mixing", startErrors);
    endtask

    task automatic phaseEntry();
        int startErrors;
        synthVoicePkg::sample_t value;
        startErrors = errorCount;
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            configureSlot(s, 8'd0, 1'b0, 1'b0);
        end
        // Entry 0 stands apart from the rest
        fillTable(-16'sd7000);
        writeReg(tableNumber(0), 16'sd9000);
        configureSlot(2, 8'd128, 1'b1, 1'b1);
        waitSamples(4);
        readSample(value);
        compareSample("phase entry 0", expectedSample(16'sd9000), value);
        writeReg(voiceOpNumber(synthRegPkg::PARAM_NOTE_ON, 2), 16'h0000);
        modelNoteOn[2] = 1'b0;
        waitSamples(4);
        readSample(value);
        compareSample("phase note off", 16'sd0, value);
        finishTest("phase", startErrors);
    endtask

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        spiNss     = 1'b1;
        spiSck     = 1'b0;
        spiMosi    = 1'b0;
        lcgState   = 32'h854c1f9a;
        errorCount = 0;
        testCount  = 0;
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            modelLevel[s]   = 8'd0;
            modelCarrier[s] = 1'b0;
            modelNoteOn[s]  = 1'b0;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        resetDefaults();
        clearPhaseSteps();
        ledWrites();
        singleCarrier();
        randomMix();
        phaseEntry();

        $display("tests run %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
